//--- files.f
+incdir+src
src/dcache_pkg.sv
src/mem_dp.sv
src/dcache.sv
src/miss_controller.sv
src/mem_latency_timer.sv
src/main_memory.sv
src/data_cache_unit.sv
tb/data_cache_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the data cache unit testbench with Verilator, runs it and checks the log
set -euo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f files.f \
    --top-module data_cache_unit_tb \
    -Mdir obj_dir \
    -o data_cache_unit_sim

./obj_dir/data_cache_unit_sim | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

//--- tb/data_cache_unit_tb.sv
// Testbench for the data cache unit, applies a stimulus table and checks against a reference model
`timescale 1ns/1ps
`include "dcache_settings.svh"

module data_cache_unit_tb;

    import dcache_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int RANDOM_TESTS   = 12;

    typedef struct packed {
        logic        is_store;
        mem_size_e   size;
        addr_t       addr;
        logic [31:0] data;
        int          stall;   // Cycles that resp_ready is held low
        int          exp_hit; // 0 miss, 1 hit, 2 taken from the tag model
    } test_vec_t;

    logic        clock;
    logic        reset;
    logic        req_valid;
    logic        req_ready;
    logic        resp_valid;
    logic        resp_ready;
    cache_req_t  req;
    cache_resp_t resp;

    test_vec_t vecs[$];
    string     names[$];

    // Reference memory and a model of the tag array
    logic [63:0]                 ref_mem [`DCACHE_MEM_BLOCKS];
    logic                        tag_valid [`DCACHE_LINES];
    logic [`DCACHE_TAG_BITS-1:0] tag_val [`DCACHE_LINES];

    addr_t rand_bases [6] = '{32'h000, 32'h008, 32'h080, 32'h088, 32'h100, 32'h408};

    int pass_count;
    int fail_count;
    bit timed_out;

    data_cache_unit UUT (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .resp_valid(resp_valid),
        .resp      (resp),
        .resp_ready(resp_ready)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic add_test(input string name, input logic is_store, input mem_size_e size,
                            input addr_t addr, input logic [31:0] data, input int stall,
                            input int exp_hit);
        test_vec_t v;
        v.is_store = is_store;
        v.size     = size;
        v.addr     = addr;
        v.data     = data;
        v.stall    = stall;
        v.exp_hit  = exp_hit;
        vecs.push_back(v);
        names.push_back(name);
    endtask

    // Lay store data over a block at the byte offset for the access size
    function automatic logic [63:0] merge_store(input logic [63:0] blk, input mem_size_e size,
                                                input logic [2:0] off, input logic [31:0] data);
        logic [63:0] res;
        res = blk;
        case (size)
            BYTE:    res[{off, 3'b000} +: 8] = data[7:0];
            HALF:    res[{off[2:1], 4'b0000} +: 16] = data[15:0];
            default: res[{off[2], 5'b00000} +: 32] = data;
        endcase
        return res;
    endfunction

    task automatic wait_req_ready(output bit ok);
        int cycles;
        cycles = 0;
        while (!req_ready && cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            #2;
            cycles++;
        end
        ok = req_ready;
    endtask

    // Latency counts edges from acceptance to the first edge that sees resp_valid
    task automatic wait_resp_valid(output int latency, output bit ok);
        latency = 1;
        while (!resp_valid && latency < TIMEOUT_CYCLES) begin
            @(posedge clock);
            #2;
            latency++;
        end
        ok = resp_valid;
    endtask

    task automatic run_test(input int i, output bit ok_run);
        test_vec_t                    v;
        string                        name;
        logic [63:0]                  exp_block;
        logic                         exp_hit;
        logic                         predicted;
        addr_t                        exp_addr;
        int                           exp_latency;
        int                           latency;
        int                           errors;
        int                           c;
        bit                           ok;
        cache_resp_t                  seen;
        logic [7:0]                   blk;
        logic [`DCACHE_LINE_BITS-1:0] idx;
        logic [`DCACHE_TAG_BITS-1:0]  tag;

        v      = vecs[i];
        name   = names[i];
        errors = 0;
        ok_run = 1'b1;
        blk    = v.addr[10:3];
        idx    = v.addr[6:3];
        tag    = v.addr[15:7];

        // Both hit and miss leave the line holding this tag
        predicted      = tag_valid[idx] && (tag_val[idx] == tag);
        tag_valid[idx] = 1'b1;
        tag_val[idx]   = tag;
        if (v.is_store) begin
            ref_mem[blk] = merge_store(ref_mem[blk], v.size, v.addr[2:0], v.data);
        end
        exp_block   = ref_mem[blk];
        exp_hit     = (v.exp_hit == 2) ? predicted : (v.exp_hit == 1);
        exp_addr    = {v.addr[31:3], 3'b000};
        exp_latency = exp_hit ? 2 : `DCACHE_MEM_LATENCY + 4;

        wait_req_ready(ok);
        if (!ok) begin
            $display("Timeout waiting for req_ready before test %s", name);
            $display("%s: FAIL", name);
            fail_count++;
            ok_run = 1'b0;
            return;
        end

        resp_ready    = (v.stall == 0);
        req_valid     = 1'b1;
        req.addr      = v.addr;
        req.is_store  = v.is_store;
        req.size      = v.size;
        req.data      = v.data;
        @(posedge clock); // Acceptance edge
        #2;
        req_valid = 1'b0;

        wait_resp_valid(latency, ok);
        if (!ok) begin
            $display("Timeout waiting for resp_valid in test %s", name);
            $display("%s: FAIL", name);
            fail_count++;
            ok_run = 1'b0;
            return;
        end

        seen = resp;
        if (resp.block !== exp_block) begin
            $display("Mismatch %s block: expected %h actual %h", name, exp_block, resp.block);
            errors++;
        end
        if (resp.hit !== exp_hit) begin
            $display("Mismatch %s hit: expected %b actual %b", name, exp_hit, resp.hit);
            errors++;
        end
        if (resp.addr !== exp_addr) begin
            $display("Mismatch %s addr: expected %h actual %h", name, exp_addr, resp.addr);
            errors++;
        end
        if (latency != exp_latency) begin
            $display("Mismatch %s latency: expected %0d actual %0d", name, exp_latency, latency);
            errors++;
        end

        // Under back-pressure the response holds and no new request is taken
        for (c = 0; c < v.stall; c++) begin
            @(posedge clock);
            #2;
            if (!resp_valid || resp !== seen) begin
                $display("Response changed while resp_ready was low in test %s", name);
                errors++;
            end
            if (req_ready) begin
                $display("req_ready rose before the response was taken in test %s", name);
                errors++;
            end
        end

        resp_ready = 1'b1;
        @(posedge clock);
        #2;
        if (resp_valid || !req_ready) begin
            $display("Controller did not return to idle after the response in test %s", name);
            errors++;
        end

        if (errors == 0) begin
            $display("%s: PASS", name);
            pass_count++;
        end else begin
            $display("%s: FAIL", name);
            fail_count++;
        end
    endtask

    initial begin
        int         n;
        int         r;
        logic [2:0] off;
        addr_t      base;
        mem_size_e  size;
        bit         ok;

        void'($urandom(32'h924a_5822));
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        for (n = 0; n < `DCACHE_MEM_BLOCKS; n++) begin
            ref_mem[n] = '0;
        end
        for (n = 0; n < `DCACHE_LINES; n++) begin
            tag_valid[n] = 1'b0;
            tag_val[n]   = '0;
        end

        // Name, store, size, address, data, stall cycles, expected hit
        add_test("first_load_miss", 1'b0, WORD, 32'h040, 32'h0, 0, 0);
        add_test("store_byte_hit", 1'b1, BYTE, 32'h045, 32'h0000_00a5, 0, 1);
        add_test("store_half_hit", 1'b1, HALF, 32'h046, 32'h0000_beef, 0, 1);
        add_test("store_word_hit", 1'b1, WORD, 32'h040, 32'h1234_5678, 0, 1);
        add_test("load_merged_hit", 1'b0, WORD, 32'h040, 32'h0, 0, 1);
        add_test("store_miss_allocate", 1'b1, HALF, 32'h2a2, 32'h0000_cafe, 0, 0);
        add_test("reload_after_store_miss", 1'b0, WORD, 32'h2a0, 32'h0, 0, 1);
        add_test("evict_same_index", 1'b0, WORD, 32'h0c0, 32'h0, 0, 0);
        add_test("reload_evicted", 1'b0, WORD, 32'h040, 32'h0, 0, 0);
        add_test("stall_load_hit", 1'b0, WORD, 32'h040, 32'h0, 5, 1);
        add_test("stall_store_miss", 1'b1, WORD, 32'h3fc, 32'hdead_beef, 3, 0);

        // Random accesses over a few lines that share indexes
        for (n = 0; n < RANDOM_TESTS; n++) begin
            r    = int'($urandom_range(2, 0));
            size = (r == 0) ? BYTE : (r == 1) ? HALF : WORD;
            off  = 3'($urandom_range(7, 0));
            if (size == HALF) off[0] = 1'b0;
            if (size == WORD) off[1:0] = 2'b00;
            base = rand_bases[$urandom_range(5, 0)];
            add_test($sformatf("rand_%0d", n), 1'($urandom_range(1, 0)), size,
                     {base[31:3], off}, $urandom(), int'($urandom_range(2, 0)), 2);
        end

        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;

        if (resp_valid || !req_ready) begin
            $display("After reset resp_valid is %b and req_ready is %b", resp_valid, req_ready);
            $display("reset_state: FAIL");
            fail_count++;
        end else begin
            $display("reset_state: PASS");
            pass_count++;
        end

        n = 0;
        while (n < vecs.size() && !timed_out) begin
            run_test(n, ok);
            if (!ok) timed_out = 1'b1; // Stop applying the table
            n++;
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src/data_cache_unit.sv
// Top level of the data cache unit, joining controller, cache and backing memory
`timescale 1ns/1ps
`include "dcache_settings.svh"

module data_cache_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    req_valid,
    input  dcache_pkg::cache_req_t  req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output dcache_pkg::cache_resp_t resp,
    input  logic                    resp_ready
);

    import dcache_pkg::*;

    localparam int MEM_AW = $clog2(`DCACHE_MEM_BLOCKS);

    cache_req_t cur_req;
    logic       hit;
    mem_block_t merged_block;
    logic       fill_en;
    mem_block_t fill_block;
    logic       mem_rd_en;
    logic       mem_rd_done;
    mem_block_t mem_rd_block;
    logic       mem_wr_en;
    mem_block_t mem_wr_block;

    miss_controller ctrl (
        .clock       (clock),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .resp_ready  (resp_ready),
        .cur_req     (cur_req),
        .hit         (hit),
        .merged_block(merged_block),
        .fill_en     (fill_en),
        .fill_block  (fill_block),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_done (mem_rd_done),
        .mem_rd_block(mem_rd_block),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_block(mem_wr_block)
    );

    dcache cache (
        .clock       (clock),
        .reset       (reset),
        .cur_req     (cur_req),
        .fill_en     (fill_en),
        .fill_block  (fill_block),
        .hit         (hit),
        .merged_block(merged_block)
    );

    // Block address is taken just above the byte offset
    main_memory memory (
        .clock   (clock),
        .reset   (reset),
        .rd_en   (mem_rd_en),
        .rd_addr (cur_req.addr[MEM_AW+2:3]),
        .rd_done (mem_rd_done),
        .rd_block(mem_rd_block),
        .wr_en   (mem_wr_en),
        .wr_addr (cur_req.addr[MEM_AW+2:3]),
        .wr_block(mem_wr_block)
    );

endmodule

//--- src/main_memory.sv
// Block-addressed backing memory with latency-timed reads and immediate writes
`timescale 1ns/1ps
`include "dcache_settings.svh"

module main_memory (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   rd_en,
    input  logic [$clog2(`DCACHE_MEM_BLOCKS)-1:0]  rd_addr,
    output logic                                   rd_done,
    output dcache_pkg::mem_block_t                 rd_block,
    input  logic                                   wr_en,
    input  logic [$clog2(`DCACHE_MEM_BLOCKS)-1:0]  wr_addr,
    input  dcache_pkg::mem_block_t                 wr_block
);

    import dcache_pkg::*;

    localparam int AW = $clog2(`DCACHE_MEM_BLOCKS);

    logic [AW-1:0]                 rd_addr_q;
    logic [AW-1:0]                 ram_raddr;
    logic                          ram_re;
    logic                          timer_busy;
    logic [`DCACHE_MEM_BLOCKS-1:0] written; // Blocks stored since reset
    logic                          rd_written;
    mem_block_t                    ram_rdata;

    // Keep re-reading the latched block while the timer runs
    assign ram_raddr = rd_en ? rd_addr : rd_addr_q;
    assign ram_re    = rd_en || timer_busy;

    mem_dp #(
        .DEPTH(`DCACHE_MEM_BLOCKS),
        .WIDTH($bits(mem_block_t))
    ) ram (
        .clock(clock),
        .reset(reset),
        .re   (ram_re),
        .raddr(ram_raddr),
        .waddr(wr_addr),
        .we   (wr_en),
        .wdata(wr_block),
        .rdata(ram_rdata)
    );

    mem_latency_timer timer (
        .clock(clock),
        .reset(reset),
        .start(rd_en),
        .busy (timer_busy),
        .done (rd_done)
    );

    // Reset clears the written map, so every block reads back as zero until stored
    assign rd_block = rd_written ? ram_rdata : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            written    <= '0;
            rd_written <= 1'b0;
        end else begin
            if (ram_re) rd_written <= written[ram_raddr]; // Tracks the RAM read
            if (wr_en) written[wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_addr_q <= rd_addr;
        end
    end

endmodule

//--- src/mem_latency_timer.sv
// Countdown that pulses done a fixed memory latency after a read starts
`timescale 1ns/1ps
`include "dcache_settings.svh"

module mem_latency_timer (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic busy,
    output logic done
);

    localparam int CW = $clog2(`DCACHE_MEM_LATENCY + 1);

    logic [CW-1:0] count;

    // Last busy cycle is the one LATENCY cycles after start
    assign done = busy && (count == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= CW'(`DCACHE_MEM_LATENCY - 1);
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_start_while_busy: assert property (
        @(posedge clock) disable iff (reset)
        start |-> !busy
    );

endmodule

//--- src/miss_controller.sv
// Request FSM for the data cache, covering lookup, refill, write-through and response hold
`timescale 1ns/1ps

module miss_controller (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    req_valid,
    input  dcache_pkg::cache_req_t  req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output dcache_pkg::cache_resp_t resp,
    input  logic                    resp_ready,
    output dcache_pkg::cache_req_t  cur_req,
    input  logic                    hit,
    input  dcache_pkg::mem_block_t  merged_block,
    output logic                    fill_en,
    output dcache_pkg::mem_block_t  fill_block,
    output logic                    mem_rd_en,
    input  logic                    mem_rd_done,
    input  dcache_pkg::mem_block_t  mem_rd_block,
    output logic                    mem_wr_en,
    output dcache_pkg::mem_block_t  mem_wr_block
);

    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_WAIT,
        FILL,
        RESPOND
    } state_e;

    state_e     state;
    state_e     next_state;
    cache_req_t req_q;

    assign req_ready  = (state == IDLE);
    assign resp_valid = (state == RESPOND);
    assign fill_en    = (state == FILL);

    // In IDLE the incoming address goes straight to the data array so the block
    // is read by the lookup cycle; the store bit is masked so nothing is written
    always_comb begin
        cur_req = req_q;
        if (state == IDLE) begin
            cur_req          = req;
            cur_req.is_store = 1'b0;
        end
    end

    // Write-through on a store hit at lookup, or on the fill of a store miss
    assign mem_wr_en    = cur_req.is_store && (((state == LOOKUP) && hit) || (state == FILL));
    assign mem_wr_block = merged_block;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (req_valid) next_state = LOOKUP;
            LOOKUP:   next_state = hit ? RESPOND : MEM_WAIT;
            MEM_WAIT: if (mem_rd_done) next_state = FILL;
            FILL:     next_state = RESPOND;
            RESPOND:  if (resp_ready) next_state = IDLE; // Hold until taken
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            mem_rd_en <= 1'b0;
        end else begin
            state     <= next_state;
            mem_rd_en <= (state == LOOKUP) && !hit; // One-cycle read pulse
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (mem_rd_done) begin
            fill_block <= mem_rd_block;
        end
        if (state == LOOKUP) begin
            resp.hit  <= hit;
            resp.addr <= {cur_req.addr[31:3], 3'b000};
        end
        if (((state == LOOKUP) && hit) || (state == FILL)) begin
            resp.block <= merged_block;
        end
    end

    a_resp_stable: assert property (
        @(posedge clock) disable iff (reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp)
    );

endmodule

//--- src/dcache.sv
// Direct-mapped tag array, hit detection and store merge for the data cache unit
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache (
    input  logic                   clock,
    input  logic                   reset,
    input  dcache_pkg::cache_req_t cur_req,
    input  logic                   fill_en,
    input  dcache_pkg::mem_block_t fill_block,
    output logic                   hit,
    output dcache_pkg::mem_block_t merged_block
);

    import dcache_pkg::*;

    localparam int INDEX_LSB = 3;
    localparam int TAG_LSB   = INDEX_LSB + `DCACHE_LINE_BITS;

    logic [`DCACHE_TAG_BITS-1:0]  cur_tag;
    logic [`DCACHE_LINE_BITS-1:0] cur_index;
    logic [2:0]                   offset;
    logic                         data_we;
    mem_block_t                   stored_block;

    dcache_tag_t [`DCACHE_LINES-1:0] tags;

    assign cur_tag   = cur_req.addr[TAG_LSB +: `DCACHE_TAG_BITS];
    assign cur_index = cur_req.addr[INDEX_LSB +: `DCACHE_LINE_BITS];
    assign offset    = cur_req.addr[2:0];

    // Refill or store hit rewrites the selected line
    assign data_we = fill_en || (hit && cur_req.is_store);

    mem_dp #(
        .DEPTH(`DCACHE_LINES),
        .WIDTH($bits(mem_block_t))
    ) data_array (
        .clock(clock),
        .reset(reset),
        .re   (1'b1),
        .raddr(cur_index),
        .waddr(cur_index),
        .we   (data_we),
        .wdata(merged_block),
        .rdata(stored_block)
    );

    assign hit = tags[cur_index].valid && (tags[cur_index].tag == cur_tag);

    // Start from the refilled or the stored block, then lay store data over it
    always_comb begin
        merged_block = fill_en ? fill_block : stored_block;
        if (cur_req.is_store) begin
            case (cur_req.size)
                BYTE:    merged_block.byte_level[offset]    = cur_req.data[7:0];
                HALF:    merged_block.half_level[offset[2:1]] = cur_req.data[15:0];
                default: merged_block.word_level[offset[2]] = cur_req.data;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tags <= '0; // All lines invalid
        end else if (fill_en) begin
            tags[cur_index].valid <= 1'b1;
            tags[cur_index].tag   <= cur_tag;
        end
    end

    // Controller only fills after a lookup miss, so a refill never races a store hit
    a_fill_not_on_store_hit: assert property (
        @(posedge clock) disable iff (reset)
        !(fill_en && hit && cur_req.is_store)
    );

endmodule

//--- src/mem_dp.sv
// Registered-read RAM with one read and one write port, used for cache data and main memory
`timescale 1ns/1ps

module mem_dp #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 64
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic                     we,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Write port, no bypass to the read side
    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data shows up one cycle after the address
    // Same-address write in that cycle still returns the old word
    always_ff @(posedge clock) begin
        if (reset) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- src/dcache_pkg.sv
// Shared address, block, tag, request and response types for the data cache unit
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t; // Byte address

    // Access width of a load or store where WORD is 32 bits
    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_e;

    // One 64-bit cache block, seen at byte, half or word granularity
    typedef union packed {
        logic [7:0][7:0]  byte_level;
        logic [3:0][15:0] half_level;
        logic [1:0][31:0] word_level;
    } mem_block_t;

    typedef struct packed {
        logic                        valid;
        logic [`DCACHE_TAG_BITS-1:0] tag;
    } dcache_tag_t;

    // Processor request, one load or store
    typedef struct packed {
        addr_t       addr;
        logic        is_store;
        mem_size_e   size;
        logic [31:0] data;
    } cache_req_t;

    // Whole block returned to the processor
    typedef struct packed {
        mem_block_t block;
        logic       hit;  // Hit as seen at lookup
        addr_t      addr; // Block-aligned
    } cache_resp_t;

endpackage

//--- src/dcache_settings.svh
// Cache geometry, backing memory size and memory latency, included wherever storage is sized
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Index width into the direct-mapped data and tag arrays
`define DCACHE_LINE_BITS 4

// Number of cache lines, one block each
`define DCACHE_LINES 16

// Tag width, taken from address bits 15 to 7
`define DCACHE_TAG_BITS 9

// Backing memory depth in blocks, addressed by address bits 10 to 3
`define DCACHE_MEM_BLOCKS 256

// Cycles from the start of a memory read to its data
`define DCACHE_MEM_LATENCY 8

`endif
